// ==== frame_align_pkg.sv ====
// frame aligner shared types
// stream byte, frame length and counter widths plus the assembled frame record
`default_nettype none

package frame_align_pkg;

   // widest frame the header can describe, also the extractor window width
   localparam int MAX_FRAME_LEN = 4;

   // header byte layout
   // top two bits hold length minus one
   localparam int HDR_LEN_HI = 7;
   localparam int HDR_LEN_LO = 6;

   // one byte of the incoming stream
   typedef logic [7:0] byte_t;

   // frame length in bytes, 1..4
   // also wide enough for a consume count of 0..4
   typedef logic [2:0] frame_len_t;

   // statistics counter, wraps on overflow
   typedef logic [15:0] count_t;

   // assembled frame
   // bytes[0] is the header byte
   // entries at or above len are zero
   typedef struct packed {
      frame_len_t                  len;
      byte_t [MAX_FRAME_LEN-1:0]   bytes;
   } frame_t;

endpackage : frame_align_pkg

`default_nettype wire

// ==== bsg_serial_in_parallel_out.sv ====
// shifting serial-in parallel-out buffer
// one word enters per cycle, a variable number leave per cycle, with same-cycle bypass
`timescale 1ns/1ps
`default_nettype none

module bsg_serial_in_parallel_out
   #(parameter int width_p   = 8
   , parameter int els_p     = 8
   , parameter int out_els_p = 4
   )
   (input  logic                                   clk_i
   , input  logic                                  reset_i

   // serial side, plain strobe with ready
   , input  logic                                  valid_i
   , input  logic [width_p-1:0]                    data_i
   , output logic                                  ready_o

   // parallel window, entry 0 is the oldest word
   , output logic [out_els_p-1:0]                  valid_o
   , output logic [out_els_p-1:0][width_p-1:0]     data_o

   // number of window entries taken this cycle
   , input  logic [$clog2(out_els_p+1)-1:0]        yumi_cnt_i
   );

   localparam int cnt_width_lp = $clog2(els_p+1);

   // stored words and their valid bits
   logic [els_p-1:0][width_p-1:0]     data_r;
   logic [els_p-1:0]                  valid_r;

   // stored words plus the incoming word, padded to twice the depth
   // so the shift below never reads past the end
   logic [2*els_p-1:0][width_p-1:0]   data_ext;
   logic [2*els_p-1:0]                valid_ext;

   // contents after removing the consumed words
   logic [els_p-1:0][width_p-1:0]     data_shift;
   logic [els_p-1:0]                  valid_shift;

   // occupancy
   logic [cnt_width_lp-1:0]           num_els_r;
   logic [cnt_width_lp-1:0]           num_els_n;

   logic                              accept;

   // room left as long as the top slot is empty
   assign ready_o = ~valid_r[els_p-1];

   assign accept = valid_i & ready_o;

   // occupancy after this cycle's push and pop
   assign num_els_n = num_els_r
                    + cnt_width_lp'(accept)
                    - cnt_width_lp'(yumi_cnt_i);

   always_comb
   begin
      // upper half stays empty
      data_ext  = '0;
      valid_ext = '0;
      data_ext[els_p-1:0]  = data_r;
      valid_ext[els_p-1:0] = valid_r;

      // the new word lands right behind the last stored one
      // num_els_r may equal els_p when full, that write goes to the pad with valid low
      data_ext[num_els_r]  = data_i;
      valid_ext[num_els_r] = accept;
   end

   // window sees the incoming word in the same cycle
   assign valid_o = valid_ext[out_els_p-1:0];
   assign data_o  = data_ext[out_els_p-1:0];

   // drop the consumed words off the bottom
   assign data_shift  = data_ext[yumi_cnt_i +: els_p];
   assign valid_shift = valid_ext[yumi_cnt_i +: els_p];

   // control state
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         num_els_r <= '0;
         valid_r   <= '0;
      end
      else
      begin
         num_els_r <= num_els_n;
         valid_r   <= valid_shift;
      end
   end

   // payload storage
   always_ff @(posedge clk_i)
   begin
      data_r <= data_shift;
   end

endmodule : bsg_serial_in_parallel_out

`default_nettype wire

// ==== frame_extract.sv ====
// frame extractor
// decodes the header at the head of the window, pops a whole frame and registers it
`timescale 1ns/1ps
`default_nettype none

module frame_extract
   import frame_align_pkg::*;
   (input  logic                              clk_i
   , input  logic                             reset_i

   // window from the buffer, entry 0 is the oldest byte
   , input  logic [MAX_FRAME_LEN-1:0]         window_valid_i
   , input  byte_t [MAX_FRAME_LEN-1:0]        window_data_i

   // bytes to take out of the buffer this cycle
   , output frame_len_t                       consume_cnt_o

   // registered frame, valid for one cycle
   , output logic                             frame_valid_o
   , output frame_t                           frame_o
   );

   // length carried by the header bits
   logic [HDR_LEN_HI-HDR_LEN_LO:0]   len_field;
   frame_len_t                       frame_len;

   // all bytes of the frame are present
   logic                             frame_complete;

   // frame as it will be registered
   frame_t                           frame_n;

   logic                             frame_valid_r;
   frame_t                           frame_r;

   assign len_field = window_data_i[0][HDR_LEN_HI:HDR_LEN_LO];

   // field holds length minus one
   assign frame_len = frame_len_t'(len_field) + frame_len_t'(1);

   always_comb
   begin
      // header itself has to be there
      frame_complete = window_valid_i[0];

      // then every byte below the length
      for (int i = 1; i < MAX_FRAME_LEN; i++)
      begin
         if (i < int'(frame_len))
         begin
            frame_complete = frame_complete & window_valid_i[i];
         end
      end
   end

   // pop the whole frame at once, or nothing
   assign consume_cnt_o = frame_complete ? frame_len : '0;

   always_comb
   begin
      frame_n.len = frame_len;

      // copy the frame bytes, zero the tail past the length
      for (int i = 0; i < MAX_FRAME_LEN; i++)
      begin
         if (i < int'(frame_len))
         begin
            frame_n.bytes[i] = window_data_i[i];
         end
         else
         begin
            frame_n.bytes[i] = '0;
         end
      end
   end

   // one-cycle pulse following every consume
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         frame_valid_r <= 1'b0;
      end
      else
      begin
         frame_valid_r <= frame_complete;
      end
   end

   // frame payload, only loaded on a consume
   // holds the last frame otherwise
   always_ff @(posedge clk_i)
   begin
      if (frame_complete)
      begin
         frame_r <= frame_n;
      end
   end

   assign frame_valid_o = frame_valid_r;
   assign frame_o       = frame_r;

endmodule : frame_extract

`default_nettype wire

// ==== frame_stats.sv ====
// frame statistics
// running totals of frames seen and of bytes carried by them, both wrap
`timescale 1ns/1ps
`default_nettype none

module frame_stats
   import frame_align_pkg::*;
   (input  logic          clk_i
   , input  logic         reset_i

   // frame pulse and its length from the extractor
   , input  logic         frame_valid_i
   , input  frame_len_t   frame_len_i

   // totals
   , output count_t       frame_count_o
   , output count_t       byte_count_o
   );

   count_t   frame_count_r;
   count_t   byte_count_r;

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         frame_count_r <= '0;
         byte_count_r  <= '0;
      end
      else if (frame_valid_i)
      begin
         // one more frame
         frame_count_r <= frame_count_r + count_t'(1);

         // plus its length in bytes
         byte_count_r  <= byte_count_r + count_t'(frame_len_i);
      end
   end

   assign frame_count_o = frame_count_r;
   assign byte_count_o  = byte_count_r;

endmodule : frame_stats

`default_nettype wire

// ==== frame_aligner_top.sv ====
// variable-length frame aligner
// byte stream in, one aligned frame per cycle out, with frame and byte totals
`timescale 1ns/1ps
`default_nettype none

module frame_aligner_top
   import frame_align_pkg::*;
   #(parameter int els_p = 8
   )
   (input  logic          clk_i
   , input  logic         reset_i

   // byte stream in
   , input  logic         valid_i
   , input  byte_t        data_i
   , output logic         ready_o

   // aligned frames out, never stalled
   , output logic         frame_valid_o
   , output frame_t       frame_o

   // statistics
   , output count_t       frame_count_o
   , output count_t       byte_count_o
   );

   // window between buffer and extractor
   logic [MAX_FRAME_LEN-1:0]    window_valid;
   byte_t [MAX_FRAME_LEN-1:0]   window_data;

   // bytes popped this cycle
   frame_len_t                  consume_cnt;

   // buffer, window width fixed to the longest frame
   bsg_serial_in_parallel_out
      #(.width_p   ($bits(byte_t))
      , .els_p     (els_p)
      , .out_els_p (MAX_FRAME_LEN)
      )
      sipo_i
      (.clk_i      (clk_i)
      , .reset_i   (reset_i)
      , .valid_i   (valid_i)
      , .data_i    (data_i)
      , .ready_o   (ready_o)
      , .valid_o   (window_valid)
      , .data_o    (window_data)
      , .yumi_cnt_i(consume_cnt)
      );

   // header decode and frame register
   frame_extract extract_i
      (.clk_i          (clk_i)
      , .reset_i       (reset_i)
      , .window_valid_i(window_valid)
      , .window_data_i (window_data)
      , .consume_cnt_o (consume_cnt)
      , .frame_valid_o (frame_valid_o)
      , .frame_o       (frame_o)
      );

   // counters follow the registered frame
   frame_stats stats_i
      (.clk_i         (clk_i)
      , .reset_i      (reset_i)
      , .frame_valid_i(frame_valid_o)
      , .frame_len_i  (frame_o.len)
      , .frame_count_o(frame_count_o)
      , .byte_count_o (byte_count_o)
      );

endmodule : frame_aligner_top

`default_nettype wire

// ==== tb_frame_checker.sv ====
// frame aligner checker
// compares every output frame and the running totals against the reference model
`timescale 1ns/1ps
`default_nettype none

module tb_frame_checker
   import frame_align_pkg::*;
   (input  logic      clk_i
   , input  logic     reset_i

   // DUT outputs under watch
   , input  logic     ready_i
   , input  logic     frame_valid_i
   , input  frame_t   frame_i
   , input  count_t   frame_count_i
   , input  count_t   byte_count_i

   // expected frame from the reference parse, one per completed frame
   , input  logic     exp_valid_i
   , input  frame_t   exp_frame_i
   , input  logic     exp_timed_i

   // test bookkeeping
   , input  int       test_id_i
   , input  logic     test_end_i
   , output int       frames_seen_o
   , output int       errors_o
   );

   // expected frames in input order, with the cycle they were queued
   frame_t   exp_q[$];
   int       cyc_q[$];
   bit       timed_q[$];

   int       cycle = 0;
   int       seen_cnt = 0;
   int       err_total = 0;
   int       test_errors = 0;
   int       test_frames = 0;
   logic     in_reset_q = 1'b0;

   // reference totals, wrap like the DUT counters
   count_t   exp_frames = '0;
   count_t   exp_bytes = '0;

   assign errors_o = err_total;

   function automatic string test_name(input int id);
      case (id)
         0:       return "reset";
         1:       return "back_to_back";
         2:       return "gaps";
         3:       return "latency";
         4:       return "counters";
         5:       return "full_buffer";
         default: return "unknown";
      endcase
   endfunction

   task automatic count_error();
      err_total   = err_total + 1;
      test_errors = test_errors + 1;
   endtask

   always @(posedge clk_i)
   begin
      frame_t   exp_f;
      int       exp_cyc;
      bit       exp_tm;

      cycle = cycle + 1;

      // first cycle after reset drops
      if (!reset_i && in_reset_q)
      begin
         if (frame_valid_i !== 1'b0)
         begin
            $display("Fail reset: frame_valid_o expected 0 actual %b", frame_valid_i);
            count_error();
         end
         if (ready_i !== 1'b1)
         begin
            $display("Fail reset: ready_o expected 1 actual %b", ready_i);
            count_error();
         end
      end

      if (!reset_i)
      begin
         // counters reflect frames popped up to the previous edge
         if (frame_count_i !== exp_frames)
         begin
            $display("Fail %s: frame_count_o expected %0d actual %0d",
                     test_name(test_id_i), exp_frames, frame_count_i);
            count_error();
         end
         if (byte_count_i !== exp_bytes)
         begin
            $display("Fail %s: byte_count_o expected %0d actual %0d",
                     test_name(test_id_i), exp_bytes, byte_count_i);
            count_error();
         end

         // queue first so a frame due this cycle is already there
         if (exp_valid_i)
         begin
            exp_q.push_back(exp_frame_i);
            cyc_q.push_back(cycle);
            timed_q.push_back(exp_timed_i);
         end

         if (frame_valid_i === 1'b1)
         begin
            seen_cnt = seen_cnt + 1;
            if (exp_q.size() == 0)
            begin
               $display("%s: the DUT emitted a frame when none was expected",
                        test_name(test_id_i));
               count_error();
            end
            else
            begin
               exp_f   = exp_q.pop_front();
               exp_cyc = cyc_q.pop_front();
               exp_tm  = timed_q.pop_front();
               if (frame_i !== exp_f)
               begin
                  $display("Fail %s: frame expected %h actual %h",
                           test_name(test_id_i), exp_f, frame_i);
                  count_error();
               end
               // pulse due in the cycle right after the last byte
               if (exp_tm && exp_cyc != cycle)
               begin
                  $display("Fail %s: frame_valid_o cycle expected %0d actual %0d",
                           test_name(test_id_i), exp_cyc, cycle);
                  count_error();
               end
               exp_frames  = exp_frames + count_t'(1);
               exp_bytes   = exp_bytes + count_t'(exp_f.len);
               test_frames = test_frames + 1;
            end
         end

         // one summary line per test
         if (test_end_i)
         begin
            if (exp_q.size() != 0)
            begin
               $display("%s: %0d expected frames never came out",
                        test_name(test_id_i), exp_q.size());
               count_error();
            end
            $display("test %-12s %0d frames, %0d errors",
                     test_name(test_id_i), test_frames, test_errors);
            test_errors = 0;
            test_frames = 0;
         end
      end

      in_reset_q = reset_i;
      frames_seen_o <= seen_cnt;
   end

endmodule : tb_frame_checker

`default_nettype wire

// ==== tb_frame_aligner.sv ====
// frame aligner testbench
// drives random LCG frames, parses the accepted bytes into expected frames and runs a watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_frame_aligner
   import frame_align_pkg::*;
   ;

   localparam int CLK_PERIOD   = 40;
   localparam int B2B_FRAMES   = 40;
   localparam int GAP_FRAMES   = 30;
   localparam int LAT_FRAMES   = 4;
   localparam int CNT_FRAMES   = 20;
   localparam int FULL_FRAMES  = 32;
   localparam int TOTAL_FRAMES = B2B_FRAMES + GAP_FRAMES + LAT_FRAMES + CNT_FRAMES + FULL_FRAMES;
   // worst case four cycles per byte with gaps plus room for reset and drains
   localparam int TIMEOUT_NS   = TOTAL_FRAMES * MAX_FRAME_LEN * CLK_PERIOD * 4
                               + 200 * CLK_PERIOD;

   logic     clk;
   logic     reset;
   logic     valid;
   byte_t    data;
   logic     ready;
   logic     frame_valid;
   frame_t   frame;
   count_t   frame_count;
   count_t   byte_count;

   // reference side
   byte_t    acc_q[$];
   logic     exp_valid = 1'b0;
   frame_t   exp_frame = '0;
   logic     exp_timed = 1'b0;
   logic     timed_mode;
   int       sent_count = 0;
   int       test_id;
   logic     test_end;
   int       frames_seen;
   int       errors;

   logic [31:0] rng_state = 32'hf7f0_e29d;

   frame_aligner_top #(.els_p(8)) frame_aligner_top_i
      (.clk_i         (clk)
      , .reset_i      (reset)
      , .valid_i      (valid)
      , .data_i       (data)
      , .ready_o      (ready)
      , .frame_valid_o(frame_valid)
      , .frame_o      (frame)
      , .frame_count_o(frame_count)
      , .byte_count_o (byte_count)
      );

   tb_frame_checker check_i
      (.clk_i         (clk)
      , .reset_i      (reset)
      , .ready_i      (ready)
      , .frame_valid_i(frame_valid)
      , .frame_i      (frame)
      , .frame_count_i(frame_count)
      , .byte_count_i (byte_count)
      , .exp_valid_i  (exp_valid)
      , .exp_frame_i  (exp_frame)
      , .exp_timed_i  (exp_timed)
      , .test_id_i    (test_id)
      , .test_end_i   (test_end)
      , .frames_seen_o(frames_seen)
      , .errors_o     (errors)
      );

   always #(CLK_PERIOD/2) clk = ~clk;

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic [31:0] next_rand();
      rng_state = lcg_step(rng_state);
      return rng_state;
   endfunction

   // length 1..4 from the top bits
   function automatic int rand_len();
      return int'(next_rand() >> 30) + 1;
   endfunction

   // header bits hold length minus one
   function automatic int ref_len(input byte_t hdr);
      return int'(hdr[7:6]) + 1;
   endfunction

   // expected frame from the head of the accepted bytes with zero tail bytes
   function automatic frame_t ref_frame();
      frame_t f;
      f = '0;
      f.len = frame_len_t'(ref_len(acc_q[0]));
      for (int i = 0; i < ref_len(acc_q[0]); i++)
      begin
         f.bytes[i] = acc_q[i];
      end
      return f;
   endfunction

   // record accepted bytes and parse whole frames off the front
   always @(posedge clk)
   begin
      int n;
      exp_valid <= 1'b0;
      if (!reset && valid && ready)
      begin
         acc_q.push_back(data);
         n = ref_len(acc_q[0]);
         if (acc_q.size() >= n)
         begin
            exp_frame  <= ref_frame();
            exp_timed  <= timed_mode;
            exp_valid  <= 1'b1;
            sent_count <= sent_count + 1;
            for (int i = 0; i < n; i++)
            begin
               void'(acc_q.pop_front());
            end
         end
      end
   end

   task automatic idle(input int n);
      valid <= 1'b0;
      repeat (n) @(posedge clk);
   endtask

   // hold the byte until the buffer takes it
   task automatic send_byte(input byte_t b);
      valid <= 1'b1;
      data  <= b;
      @(posedge clk);
      while (!ready)
      begin
         @(posedge clk);
      end
      valid <= 1'b0;
   endtask

   task automatic send_frame(input int len, input bit gappy);
      logic [31:0] r;
      byte_t       b;
      for (int i = 0; i < len; i++)
      begin
         r = next_rand();
         if (i == 0)
         begin
            b = {2'(len - 1), r[13:8]};
         end
         else
         begin
            b = r[15:8];
         end
         if (gappy)
         begin
            idle(int'(r[25:24]));
         end
         send_byte(b);
      end
   endtask

   // wait until every parsed frame has come out
   task automatic drain();
      @(posedge clk);
      while (frames_seen != sent_count)
      begin
         @(posedge clk);
      end
   endtask

   task automatic end_test();
      drain();
      @(posedge clk);
      test_end <= 1'b1;
      @(posedge clk);
      test_end <= 1'b0;
   endtask

   initial
   begin
      clk        = 1'b0;
      reset      = 1'b1;
      valid      = 1'b0;
      data       = '0;
      test_id    = 0;
      test_end   = 1'b0;
      timed_mode = 1'b0;
      repeat (4) @(posedge clk);
      reset <= 1'b0;

      // reset values are checked on the first cycle out of reset
      idle(2);
      end_test();

      test_id <= 1;
      repeat (B2B_FRAMES) send_frame(rand_len(), 1'b0);
      end_test();

      test_id <= 2;
      repeat (GAP_FRAMES) send_frame(rand_len(), 1'b1);
      end_test();

      // one frame at a time into an empty buffer
      test_id    <= 3;
      timed_mode <= 1'b1;
      for (int len = 1; len <= LAT_FRAMES; len++)
      begin
         send_frame(len, 1'b0);
         drain();
      end
      timed_mode <= 1'b0;
      end_test();

      test_id <= 4;
      repeat (CNT_FRAMES) send_frame(rand_len(), 1'b1);
      end_test();

      // short and long frames back to back
      test_id <= 5;
      repeat (FULL_FRAMES / 8)
      begin
         repeat (4) send_frame(1, 1'b0);
         repeat (4) send_frame(4, 1'b0);
      end
      end_test();

      // totals are final once the checker has handled the last edge
      @(negedge clk);
      $display("frames checked %0d, errors %0d", frames_seen, errors);
      if (errors == 0)
      begin
         $display("Test passed");
      end
      else
      begin
         $display("Test failed");
      end
      $finish;
   end

   initial
   begin
      #(TIMEOUT_NS);
      $display("timeout: the run did not finish, %0d of %0d frames came out",
               frames_seen, sent_count);
      $display("Test failed");
      $finish;
   end

endmodule : tb_frame_aligner

`default_nettype wire

// ==== frame_aligner_top.f ====
frame_align_pkg.sv
bsg_serial_in_parallel_out.sv
frame_extract.sv
frame_stats.sv
frame_aligner_top.sv
tb_frame_checker.sv
tb_frame_aligner.sv

// ==== Makefile ====
TOP   = tb_frame_aligner
FLIST = frame_aligner_top.f

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f $(FLIST)

sim:
	verilator --binary --timing --top-module $(TOP) -f $(FLIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir
